/* include/mlaccel_defines.svh */
// shared widths, sizes, pipeline offsets and opcode numbers for the accelerator RTL and testbench
`ifndef MLACCEL_DEFINES_SVH
`define MLACCEL_DEFINES_SVH

// memory word and address widths
`define MLACCEL_WORD_W 64
`define MLACCEL_ADDR_W 16

// instruction field widths
`define MLACCEL_MADDR_W 17
`define MLACCEL_CADDR_W 9

`define MLACCEL_COEFF_DEPTH 512

// a stage-2 read and a stage-7 write are this many cycles apart
`define MLACCEL_WR_DIST 5

`define OP_LOADCOEFF 6'd5
`define OP_SETVBP 6'd8
`define OP_ADDVBP 6'd9
`define OP_STORE 6'd16
`define OP_RELU 6'd20
`define OP_LDSET0 6'd29
`define OP_MACC 6'd40
`define OP_MACCZ 6'd42

`endif

/* verilog/mlaccel_pkg.sv */
// types shared by the accelerator pipeline, imported by the RTL modules and the testbench
`default_nettype none
`include "mlaccel_defines.svh"

package mlaccel_pkg;

	// instruction fields
	typedef logic [`MLACCEL_MADDR_W-1:0] maddr_t;
	typedef logic [`MLACCEL_CADDR_W-1:0] caddr_t;
	typedef logic [5:0] opcode_t;

	// bits 31:15 address, 14:6 coefficient slot or shift, 5:0 opcode
	typedef struct packed {
		maddr_t maddr;
		caddr_t caddr;
		opcode_t opcode;
	} insn_t;

	// one memory word, also the width of a coefficient slot
	typedef logic [`MLACCEL_WORD_W-1:0] word_t;

	typedef logic signed [31:0] acc_t;

	// eight 16-bit products need 19 bits, one more keeps the sum safe
	typedef logic signed [19:0] sum_t;

endpackage

`default_nettype wire

/* verilog/stage_delay.sv */
// valid-tagged shift register of fixed depth that exposes every stage as a tap
`default_nettype none

module stage_delay #(
	parameter type payload_t = logic [7:0],
	parameter int DEPTH = 2
) (
	input logic clock,
	input logic reset,
	input logic in_valid,
	input payload_t in_data,
	output logic out_valid [DEPTH],
	output payload_t out_data [DEPTH]
);

	// tap i holds what entered i+1 cycles ago
	always_ff @(posedge clock) begin
		out_data[0] <= in_data;
		for (int i = 1; i < DEPTH; i++) begin
			out_data[i] <= out_data[i-1];
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < DEPTH; i++) begin
				out_valid[i] <= 1'b0;
			end
		end else begin
			out_valid[0] <= in_valid;
			for (int i = 1; i < DEPTH; i++) begin
				out_valid[i] <= out_valid[i-1];
			end
		end
	end

endmodule

`default_nettype wire

/* verilog/mlaccel_issue.sv */
// command acceptance, memory interlock and read issue for pipeline stages 1 and 2
`default_nettype none
`include "mlaccel_defines.svh"

module mlaccel_issue (
	input logic clock,
	input logic reset,
	input logic cmd_valid,
	output logic cmd_ready,
	input mlaccel_pkg::insn_t cmd_insn,
	output logic s2_valid,
	output mlaccel_pkg::insn_t s2_insn,
	output logic rd_en,
	output logic [`MLACCEL_ADDR_W-1:0] rd_addr,
	output logic wr_busy_stage1
);
	import mlaccel_pkg::*;

	logic s1_valid;
	insn_t s1_insn;
	maddr_t vbp;
	maddr_t vbp_addr;
	logic is_read;
	logic is_write;
	logic is_macc;
	logic stall;
	logic advance;

	// bit 0 marks the memory cycle right after this one as taken by a write
	logic [`MLACCEL_WR_DIST-1:0] wr_res;

	assign is_macc = s1_insn.opcode == `OP_MACC || s1_insn.opcode == `OP_MACCZ;
	assign is_read = is_macc || s1_insn.opcode == `OP_LOADCOEFF ||
		s1_insn.opcode == `OP_LDSET0;
	assign is_write = s1_insn.opcode == `OP_STORE || s1_insn.opcode == `OP_RELU;

	// writes never wait, a read waits while its stage-2 cycle belongs to a store
	assign stall = s1_valid && is_read && wr_res[0];
	assign advance = s1_valid && !stall;
	assign cmd_ready = !stall;
	assign wr_busy_stage1 = s1_valid;

	// the sum wraps at 17 bits before dropping the lane bit
	assign vbp_addr = s1_insn.maddr + vbp;
	assign rd_en = advance && is_read;
	assign rd_addr = is_macc ? vbp_addr[`MLACCEL_MADDR_W-1:1] :
		s1_insn.maddr[`MLACCEL_MADDR_W-1:1];

	always_ff @(posedge clock) begin
		if (reset) begin
			s1_valid <= 1'b0;
			s2_valid <= 1'b0;
			wr_res <= '0;
			vbp <= '0;
		end else begin
			// a store leaving now writes WR_DIST+1 cycles later
			wr_res <= {advance && is_write, wr_res[`MLACCEL_WR_DIST-1:1]};
			s2_valid <= advance;
			if (!stall) begin
				s1_valid <= cmd_valid;
			end
			if (advance && s1_insn.opcode == `OP_SETVBP) begin
				vbp <= s1_insn.maddr;
			end
			if (advance && s1_insn.opcode == `OP_ADDVBP) begin
				vbp <= vbp + s1_insn.maddr;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (!stall) begin
			s1_insn <= cmd_insn;
		end
		s2_insn <= s1_insn;
	end

endmodule

`default_nettype wire

/* verilog/mlaccel_coeff_store.sv */
// coefficient slot memory with a registered read port and write-to-read forwarding
`default_nettype none
`include "mlaccel_defines.svh"

module mlaccel_coeff_store (
	input logic clock,
	input logic [`MLACCEL_CADDR_W-1:0] rd_slot,
	output mlaccel_pkg::word_t rd_data,
	input logic wr_en,
	input logic [`MLACCEL_CADDR_W-1:0] wr_slot,
	input mlaccel_pkg::word_t wr_data
);
	import mlaccel_pkg::*;

	word_t slots [`MLACCEL_COEFF_DEPTH];

	always_ff @(posedge clock) begin
		if (wr_en) begin
			slots[wr_slot] <= wr_data;
		end
	end

	// a MACC right behind its LoadCoeff reads the slot in the cycle it is written
	always_ff @(posedge clock) begin
		if (wr_en && wr_slot == rd_slot) begin
			rd_data <= wr_data;
		end else begin
			rd_data <= slots[rd_slot];
		end
	end

endmodule

`default_nettype wire

/* verilog/mlaccel_dot8.sv */
// eight signed byte products summed over two register stages
`default_nettype none

module mlaccel_dot8 (
	input logic clock,
	input mlaccel_pkg::word_t a,
	input mlaccel_pkg::word_t b,
	output mlaccel_pkg::sum_t sum
);
	import mlaccel_pkg::*;

	logic signed [15:0] prod [8];
	sum_t pair [4];
	sum_t total;

	always_ff @(posedge clock) begin
		for (int i = 0; i < 8; i++) begin
			prod[i] <= $signed(a[i*8 +: 8]) * $signed(b[i*8 +: 8]);
		end
	end

	// pairwise first, then the four partial sums
	always_comb begin
		for (int i = 0; i < 4; i++) begin
			pair[i] = sum_t'(prod[2*i]) + sum_t'(prod[2*i+1]);
		end
		total = (pair[0] + pair[1]) + (pair[2] + pair[3]);
	end

	always_ff @(posedge clock) begin
		sum <= total;
	end

endmodule

`default_nettype wire

/* verilog/mlaccel_accumulate.sv */
// accumulator update in stage 6 and the shifted, saturated output byte for stores
`default_nettype none
`include "mlaccel_defines.svh"

module mlaccel_accumulate (
	input logic clock,
	input logic reset,
	input logic s6_valid,
	input mlaccel_pkg::insn_t s6_insn,
	input mlaccel_pkg::sum_t sum,
	input mlaccel_pkg::word_t ld_data,
	output logic [7:0] out_byte
);
	import mlaccel_pkg::*;

	acc_t acc;
	acc_t shifted;
	logic [7:0] sat;
	logic relu;

	// the coefficient field doubles as the shift amount for stores
	assign shifted = acc >>> s6_insn.caddr;
	assign relu = s6_insn.opcode == `OP_RELU;

	always_comb begin
		if (shifted > 127) begin
			sat = 8'h7f;
		end else if (shifted < -128) begin
			sat = 8'h80;
		end else begin
			sat = shifted[7:0];
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			acc <= '0;
		end else if (s6_valid) begin
			case (s6_insn.opcode)
				`OP_MACC: acc <= acc + acc_t'(sum);
				`OP_MACCZ: acc <= acc_t'(sum);
				`OP_LDSET0: acc <= acc_t'(ld_data[31:0]);
				default: acc <= acc;
			endcase
		end
	end

	// the byte sees the accumulator as left by everything issued before
	always_ff @(posedge clock) begin
		if (relu && sat[7]) begin
			out_byte <= 8'h00;
		end else begin
			out_byte <= sat;
		end
	end

endmodule

`default_nettype wire

/* verilog/mlaccel_writeback.sv */
// memory port driver: registered read issue, stage-7 byte writes and the shared address mux
`default_nettype none
`include "mlaccel_defines.svh"

module mlaccel_writeback (
	input logic clock,
	input logic reset,
	input logic s7_valid,
	input mlaccel_pkg::insn_t s7_insn,
	input logic [7:0] byte_in,
	input logic rd_en,
	input logic [`MLACCEL_ADDR_W-1:0] rd_addr,
	output logic mem_ren,
	output logic [7:0] mem_wen,
	output logic [`MLACCEL_ADDR_W-1:0] mem_addr,
	output mlaccel_pkg::word_t mem_wdata
);
	import mlaccel_pkg::*;

	logic store_op;
	logic ren_q;
	logic [`MLACCEL_ADDR_W-1:0] raddr_q;

	// the read request is made in stage 1 and goes out in stage 2
	always_ff @(posedge clock) begin
		if (reset) begin
			ren_q <= 1'b0;
		end else begin
			ren_q <= rd_en;
		end
	end

	always_ff @(posedge clock) begin
		raddr_q <= rd_addr;
	end

	assign store_op = s7_valid &&
		(s7_insn.opcode == `OP_STORE || s7_insn.opcode == `OP_RELU);

	// maddr bit 0 picks the byte lane inside the word
	assign mem_wen = !store_op ? 8'b00 : (s7_insn.maddr[0] ? 8'b10 : 8'b01);
	assign mem_wdata = word_t'({byte_in, byte_in});

	assign mem_ren = ren_q;
	// the interlock keeps reads and writes apart, so one address bus is enough
	assign mem_addr = ren_q ? raddr_q : s7_insn.maddr[`MLACCEL_MADDR_W-1:1];

endmodule

`default_nettype wire

/* verilog/mlaccel_top.sv */
// accelerator compute pipeline top level that connects the stages and reports busy
`default_nettype none
`include "mlaccel_defines.svh"

module mlaccel_top (
	input logic clock,
	input logic reset,
	output logic busy,
	input logic cmd_valid,
	output logic cmd_ready,
	input mlaccel_pkg::insn_t cmd_insn,
	output logic mem_ren,
	output logic [7:0] mem_wen,
	output logic [`MLACCEL_ADDR_W-1:0] mem_addr,
	output mlaccel_pkg::word_t mem_wdata,
	input mlaccel_pkg::word_t mem_rdata
);
	import mlaccel_pkg::*;

	// stage taps of the instruction pipe, index 0 is stage 3
	localparam int S3 = 0;
	localparam int S4 = 1;
	localparam int S5 = 2;
	localparam int S6 = 3;
	localparam int S7 = 4;
	localparam int LD_DEPTH = 2;

	logic s1_busy;
	logic s2_valid;
	insn_t s2_insn;
	logic rd_en;
	logic [`MLACCEL_ADDR_W-1:0] rd_addr;
	logic stage_valid [`MLACCEL_WR_DIST];
	insn_t stage_insn [`MLACCEL_WR_DIST];
	logic ld_valid [LD_DEPTH];
	word_t ld_word [LD_DEPTH];
	word_t s6_ld_data;
	word_t coeff;
	sum_t sum;
	logic [7:0] out_byte;

	mlaccel_issue issue (
		.clock(clock),
		.reset(reset),
		.cmd_valid(cmd_valid),
		.cmd_ready(cmd_ready),
		.cmd_insn(cmd_insn),
		.s2_valid(s2_valid),
		.s2_insn(s2_insn),
		.rd_en(rd_en),
		.rd_addr(rd_addr),
		.wr_busy_stage1(s1_busy)
	);

	stage_delay #(.payload_t(insn_t), .DEPTH(`MLACCEL_WR_DIST)) insn_pipe (
		.clock(clock),
		.reset(reset),
		.in_valid(s2_valid),
		.in_data(s2_insn),
		.out_valid(stage_valid),
		.out_data(stage_insn)
	);

	// LoadCoeff data lands in stage 4 together with the slot it overwrites
	mlaccel_coeff_store coeff_store (
		.clock(clock),
		.rd_slot(stage_insn[S3].caddr),
		.rd_data(coeff),
		.wr_en(stage_valid[S4] && stage_insn[S4].opcode == `OP_LOADCOEFF),
		.wr_slot(stage_insn[S4].caddr),
		.wr_data(mem_rdata)
	);

	mlaccel_dot8 dot8 (
		.clock(clock),
		.a(mem_rdata),
		.b(coeff),
		.sum(sum)
	);

	// LdSet0 data waits two cycles to meet the accumulator in stage 6
	stage_delay #(.payload_t(word_t), .DEPTH(LD_DEPTH)) ld_pipe (
		.clock(clock),
		.reset(reset),
		.in_valid(stage_valid[S4] && stage_insn[S4].opcode == `OP_LDSET0),
		.in_data(mem_rdata),
		.out_valid(ld_valid),
		.out_data(ld_word)
	);

	assign s6_ld_data = ld_valid[LD_DEPTH-1] ? ld_word[LD_DEPTH-1] : '0;

	mlaccel_accumulate accumulate (
		.clock(clock),
		.reset(reset),
		.s6_valid(stage_valid[S6]),
		.s6_insn(stage_insn[S6]),
		.sum(sum),
		.ld_data(s6_ld_data),
		.out_byte(out_byte)
	);

	mlaccel_writeback writeback (
		.clock(clock),
		.reset(reset),
		.s7_valid(stage_valid[S7]),
		.s7_insn(stage_insn[S7]),
		.byte_in(out_byte),
		.rd_en(rd_en),
		.rd_addr(rd_addr),
		.mem_ren(mem_ren),
		.mem_wen(mem_wen),
		.mem_addr(mem_addr),
		.mem_wdata(mem_wdata)
	);

	assign busy = s1_busy || s2_valid || stage_valid[S3] || stage_valid[S4] ||
		stage_valid[S5] || stage_valid[S6] || stage_valid[S7];

endmodule

`default_nettype wire

/* sim/mlaccel_assert.sv */
// concurrent checks on the memory port and reset state, bound into the accelerator top level
`default_nettype none

module mlaccel_assert (
	input logic clock,
	input logic reset,
	input logic busy,
	input logic mem_ren,
	input logic [7:0] mem_wen
);
	timeunit 1ns;
	timeprecision 1ps;

	// read by the testbench when it sums up the run
	int failures = 0;

	// the interlock leaves room for one memory access per cycle
	one_access: assert property (@(posedge clock) disable iff (reset)
		!(mem_ren && mem_wen != 8'h00))
	else begin
		failures++;
		$error("memory read and write are active in the same cycle");
	end

	// a read is always issued by an instruction that is still in flight
	read_in_flight: assert property (@(posedge clock) disable iff (reset)
		mem_ren |-> busy)
	else begin
		failures++;
		$error("mem_ren is high while the pipeline is idle");
	end

	quiet_after_reset: assert property (@(posedge clock) reset |=> mem_wen == 8'h00)
	else begin
		failures++;
		$error("mem_wen is active in the cycle after reset");
	end

endmodule

bind mlaccel_top mlaccel_assert chk (
	.clock(clock),
	.reset(reset),
	.busy(busy),
	.mem_ren(mem_ren),
	.mem_wen(mem_wen)
);

`default_nettype wire

/* sim/mlaccel_tb.sv */
// testbench for the accelerator pipeline that runs a table of short programs against a memory model
`default_nettype none
`include "mlaccel_defines.svh"

module mlaccel_tb;
	timeunit 1ns;
	timeprecision 1ps;

	import mlaccel_pkg::*;

	localparam int NROWS = 9;
	localparam int MAXLEN = 32;
	localparam int OUT_BASE = 200;
	localparam int OUT_WORDS = 64;
	localparam int MAX_CYCLES = 200 * (NROWS + 1);

	logic clock = 1'b0;
	logic reset;
	logic busy;
	logic cmd_valid;
	logic cmd_ready;
	insn_t cmd_insn;
	logic mem_ren;
	logic [7:0] mem_wen;
	logic [`MLACCEL_ADDR_W-1:0] mem_addr;
	word_t mem_wdata;
	word_t mem_rdata = '0;

	// model memory, and the reference state that follows the opcode rules one by one
	word_t mem [1 << `MLACCEL_ADDR_W];
	word_t ref_mem [1 << `MLACCEL_ADDR_W];
	word_t ref_coeff [`MLACCEL_COEFF_DEPTH];
	acc_t ref_acc;
	maddr_t ref_vbp;

	logic [1:0] rd_pend = 2'b00;
	logic [`MLACCEL_ADDR_W-1:0] rd_addr_q [2];

	// test table, one program per row
	string row_name [NROWS];
	insn_t prog [NROWS][MAXLEN];
	int prog_len [NROWS];
	int row_addr [NROWS];
	int row_lane [NROWS];
	logic row_fixed [NROWS];
	logic [7:0] row_byte [NROWS];

	logic [31:0] rng;
	int rows;
	int cur;
	int cycles = 0;
	int tests;
	int failed;

	mlaccel_top dut (
		.clock(clock),
		.reset(reset),
		.busy(busy),
		.cmd_valid(cmd_valid),
		.cmd_ready(cmd_ready),
		.cmd_insn(cmd_insn),
		.mem_ren(mem_ren),
		.mem_wen(mem_wen),
		.mem_addr(mem_addr),
		.mem_wdata(mem_wdata),
		.mem_rdata(mem_rdata)
	);

	always #2 clock = ~clock;

	// read data appears in the second cycle after mem_ren, writes follow the byte enables
	always @(negedge clock) begin
		if (rd_pend[1]) begin
			mem_rdata <= mem[rd_addr_q[1]];
		end
		rd_pend <= {rd_pend[0], mem_ren};
		rd_addr_q[1] <= rd_addr_q[0];
		rd_addr_q[0] <= mem_addr;
		for (int b = 0; b < 8; b++) begin
			if (mem_wen[b]) begin
				mem[mem_addr][8*b +: 8] <= mem_wdata[8*b +: 8];
			end
		end
	end

	always @(posedge clock) begin
		cycles <= cycles + 1;
		if (cycles >= MAX_CYCLES) begin
			$display("error: the run did not finish within %0d cycles", MAX_CYCLES);
			$display("Test failures found");
			$finish;
		end
	end

	function automatic logic [31:0] lcg_next(logic [31:0] state);
		return state * 32'd1664525 + 32'd1013904223;
	endfunction

	task automatic begin_row(string name, int addr, int lane, logic fixed, logic [7:0] value);
		cur = rows;
		rows++;
		row_name[cur] = name;
		row_addr[cur] = addr;
		row_lane[cur] = lane;
		row_fixed[cur] = fixed;
		row_byte[cur] = value;
		prog_len[cur] = 0;
	endtask

	task automatic add_insn(int op, int maddr, int caddr);
		insn_t insn;
		insn.maddr = maddr[`MLACCEL_MADDR_W-1:0];
		insn.caddr = caddr[`MLACCEL_CADDR_W-1:0];
		insn.opcode = op[5:0];
		prog[cur][prog_len[cur]] = insn;
		prog_len[cur]++;
	endtask

	// the whole address space gets a pattern, the low words get random data
	task automatic fill_memory();
		for (int a = 0; a < (1 << `MLACCEL_ADDR_W); a++) begin
			mem[a] = {a[15:0] ^ 16'ha5c3, ~a[15:0], a[15:0] * 16'd3, a[15:0]};
		end
		for (int a = 0; a < 64; a++) begin
			rng = lcg_next(rng);
			mem[a][31:0] = rng;
			rng = lcg_next(rng);
			mem[a][63:32] = rng;
		end
		mem[100] = 64'h0000_0000_0000_1234;
		mem[101] = 64'h0000_0000_ffff_f000;
		mem[102] = 64'h0000_0000_0000_0123;
		for (int a = 0; a < (1 << `MLACCEL_ADDR_W); a++) begin
			ref_mem[a] = mem[a];
		end
	endtask

	// store addresses are word*2+lane, LdSet0 words 100..102 hold fixed values
	task automatic build_table();
		int op;
		begin_row("coeff_maccz", 200, 1, 1'b0, 8'h00);
		add_insn(`OP_LOADCOEFF, 6, 7);
		add_insn(`OP_MACCZ, 10, 7);
		add_insn(`OP_STORE, 401, 0);
		begin_row("clamp_high", 201, 0, 1'b1, 8'h7f);
		add_insn(`OP_LDSET0, 200, 0);
		add_insn(`OP_STORE, 402, 0);
		begin_row("shift_4", 201, 1, 1'b1, 8'h12);
		add_insn(`OP_LDSET0, 204, 0);
		add_insn(`OP_STORE, 403, 4);
		begin_row("macc_shift_20", 202, 0, 1'b0, 8'h00);
		add_insn(`OP_LDSET0, 204, 0);
		add_insn(`OP_MACC, 12, 7);
		add_insn(`OP_MACC, 14, 7);
		add_insn(`OP_MACC, 16, 7);
		add_insn(`OP_STORE, 404, 4);
		add_insn(`OP_STORE, 405, 20);
		begin_row("clamp_low", 203, 0, 1'b1, 8'h80);
		add_insn(`OP_LDSET0, 202, 0);
		add_insn(`OP_STORE, 406, 0);
		begin_row("relu_negative", 203, 1, 1'b1, 8'h00);
		add_insn(`OP_LDSET0, 202, 0);
		add_insn(`OP_RELU, 407, 0);
		begin_row("relu_positive", 204, 1, 1'b0, 8'h00);
		add_insn(`OP_LDSET0, 204, 0);
		add_insn(`OP_STORE, 408, 2);
		add_insn(`OP_RELU, 409, 2);
		begin_row("vbp_macc", 205, 0, 1'b0, 8'h00);
		add_insn(`OP_SETVBP, 20, 0);
		add_insn(`OP_ADDVBP, 6, 0);
		add_insn(`OP_LOADCOEFF, 4, 9);
		add_insn(`OP_MACCZ, 10, 9);
		add_insn(`OP_ADDVBP, 2, 0);
		add_insn(`OP_MACC, 10, 9);
		add_insn(`OP_STORE, 410, 3);
		// reads stay below word 162 and stores land in words 206..229, so no store feeds a read
		begin_row("dense_random", 206, 0, 1'b0, 8'h00);
		for (int s = 0; s < 4; s++) begin
			add_insn(`OP_LOADCOEFF, 80 + 2 * s, s);
		end
		for (int n = 0; n < 24; n++) begin
			rng = lcg_next(rng);
			case (rng[18:16])
				3'd0, 3'd1: op = `OP_MACC;
				3'd2: op = `OP_MACCZ;
				3'd3: op = `OP_LOADCOEFF;
				3'd4, 3'd5: op = `OP_STORE;
				3'd6: op = `OP_RELU;
				default: op = `OP_ADDVBP;
			endcase
			if (op == `OP_STORE || op == `OP_RELU) begin
				add_insn(op, 412 + rng[5:0] % 48, rng[13:10]);
			end else if (op == `OP_ADDVBP) begin
				add_insn(op, rng[2:0], 0);
			end else begin
				add_insn(op, rng[6:0], rng[9:8]);
			end
		end
	endtask

	task automatic ref_exec(insn_t i);
		logic [`MLACCEL_MADDR_W-1:0] a;
		word_t w;
		word_t c;
		acc_t s;
		acc_t v;
		logic [7:0] b;
		a = i.maddr + ref_vbp;
		case (i.opcode)
			`OP_LOADCOEFF: ref_coeff[i.caddr] = ref_mem[i.maddr[16:1]];
			`OP_SETVBP: ref_vbp = i.maddr;
			`OP_ADDVBP: ref_vbp = ref_vbp + i.maddr;
			`OP_LDSET0: ref_acc = ref_mem[i.maddr[16:1]][31:0];
			`OP_MACC, `OP_MACCZ: begin
				w = ref_mem[a[16:1]];
				c = ref_coeff[i.caddr];
				s = 0;
				for (int k = 0; k < 8; k++) begin
					s = s + $signed(w[8*k +: 8]) * $signed(c[8*k +: 8]);
				end
				ref_acc = (i.opcode == `OP_MACCZ) ? s : ref_acc + s;
			end
			`OP_STORE, `OP_RELU: begin
				v = ref_acc >>> i.caddr;
				if (v > 127) begin
					b = 8'h7f;
				end else if (v < -128) begin
					b = 8'h80;
				end else begin
					b = v[7:0];
				end
				if (i.opcode == `OP_RELU && b[7]) begin
					b = 8'h00;
				end
				ref_mem[i.maddr[16:1]][8*i.maddr[0] +: 8] = b;
			end
			default: ;
		endcase
	endtask

	task automatic run_program(int r);
		logic taken;
		for (int n = 0; n < prog_len[r]; n++) begin
			cmd_valid = 1'b1;
			cmd_insn = prog[r][n];
			taken = 1'b0;
			// cmd_ready only moves on the rising edge, so it is steady here
			while (!taken) begin
				taken = cmd_ready;
				@(negedge clock);
			end
			ref_exec(prog[r][n]);
		end
		cmd_valid = 1'b0;
		while (busy) begin
			@(negedge clock);
		end
	endtask

	task automatic check_row(int r);
		word_t expected;
		int bad;
		expected = ref_mem[row_addr[r]];
		if (row_fixed[r]) begin
			expected[8*row_lane[r] +: 8] = row_byte[r];
		end
		bad = 0;
		if (mem[row_addr[r]] !== expected) begin
			$display("mismatch %s: expected %h, actual %h", row_name[r], expected,
				mem[row_addr[r]]);
			bad = 1;
		end
		for (int a = OUT_BASE; a < OUT_BASE + OUT_WORDS; a++) begin
			if (a != row_addr[r] && mem[a] !== ref_mem[a]) begin
				$display("mismatch %s word %0d: expected %h, actual %h", row_name[r], a,
					ref_mem[a], mem[a]);
				bad = 1;
			end
		end
		if (bad == 0) begin
			$display("pass %s", row_name[r]);
		end
		tests++;
		failed += bad;
	endtask

	task automatic check_idle();
		int bad;
		bad = 0;
		repeat (3) begin
			@(negedge clock);
			if (cmd_ready !== 1'b1 || busy !== 1'b0) begin
				$display("mismatch reset_idle: expected ready 1 busy 0, actual ready %b busy %b",
					cmd_ready, busy);
				bad = 1;
			end
			if (mem_wen !== 8'h00) begin
				$display("mismatch reset_idle: expected 00, actual %h", mem_wen);
				bad = 1;
			end
		end
		if (bad == 0) begin
			$display("pass reset_idle");
		end
		tests++;
		failed += bad;
	endtask

	initial begin
		reset = 1'b1;
		cmd_valid = 1'b0;
		cmd_insn = '0;
		rng = 32'hc3d0;
		rows = 0;
		tests = 0;
		failed = 0;
		ref_acc = '0;
		ref_vbp = '0;
		fill_memory();
		build_table();
		repeat (10) @(negedge clock);
		reset = 1'b0;
		check_idle();
		for (int r = 0; r < NROWS; r++) begin
			run_program(r);
			check_row(r);
		end
		tests++;
		if (dut.chk.failures != 0) begin
			$display("error: %0d memory port assertions failed", dut.chk.failures);
			failed++;
		end else begin
			$display("pass memory_port_assertions");
		end
		$display("%0d tests run, %0d failed", tests, failed);
		if (failed == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* tb.f */
+incdir+include
verilog/mlaccel_pkg.sv
verilog/stage_delay.sv
verilog/mlaccel_issue.sv
verilog/mlaccel_coeff_store.sv
verilog/mlaccel_dot8.sv
verilog/mlaccel_accumulate.sv
verilog/mlaccel_writeback.sv
verilog/mlaccel_top.sv
sim/mlaccel_assert.sv
sim/mlaccel_tb.sv

/* Bender.yml */
package:
  name: mlaccel

export_include_dirs:
  - include

sources:
  - files:
      - verilog/mlaccel_pkg.sv
      - verilog/stage_delay.sv
      - verilog/mlaccel_issue.sv
      - verilog/mlaccel_coeff_store.sv
      - verilog/mlaccel_dot8.sv
      - verilog/mlaccel_accumulate.sv
      - verilog/mlaccel_writeback.sv
      - verilog/mlaccel_top.sv
  - target: simulation
    files:
      - sim/mlaccel_assert.sv
      - sim/mlaccel_tb.sv
